//--- tb.f
common/gf_pkg.sv
common/bch_pkg.sv
src/syndrome/bch_syndrome.sv
src/error_dec/bch_chien.sv
src/error_dec/bch_error_dec.sv
src/bch_correct.sv
src/bch_decoder_top.sv
dv/bch_assert.sv
dv/bch_checker.sv
dv/bch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the BCH decoder testbench with Verilator, run it and check for a pass
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module bch_tb -f tb.f -o bch_sim || exit 1
sim_out="$(./obj_dir/bch_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qx "RESULT: PASS" && exit 0 || exit 1

//--- dv/bch_tb.sv
`timescale 1ns/1ps

module bch_tb import bch_pkg::*; ();

	localparam int num_decodes = 300;
	localparam int max_cycles = num_decodes * 20 + 100; // at most 20 cycles per decode

	logic clk = 1'b0;
	logic rst_n;
	logic start;
	bch_word_t word_in;
	bch_word_t clean; // codeword that word_in was made from
	logic busy;
	bch_word_t word_out;
	bch_err_class_t err_class;
	logic out_valid;
	int cycle_count = 0;

	always #4 clk = ~clk; // 8 ns period

	bch_decoder_top i_bch_decoder_top (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.word_in(word_in),
		.busy(busy),
		.word_out(word_out),
		.err_class(err_class),
		.out_valid(out_valid)
	);

	bch_checker i_bch_checker (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.word_in(word_in),
		.clean(clean),
		.busy(busy),
		.out_valid(out_valid),
		.word_out(word_out),
		.err_class(err_class)
	);

	bind bch_decoder_top bch_assert i_bch_assert (
		.clk(clk),
		.rst_n(rst_n),
		.busy(busy),
		.valid(valid),
		.first(first),
		.out_valid(out_valid)
	);

	// message in bits 14 to 8, remainder of m(x) x^8 by
	// g(x) = x^8 + x^7 + x^6 + x^4 + 1 in bits 7 to 0
	function automatic logic [14:0] encode(input logic [6:0] msg);
		logic [14:0] r;
		r = {msg, 8'h00};
		for (int i = 14; i >= 8; i--)
			if (r[i])
				r ^= 15'(9'h1d1) << (i - 8);
		return {msg, r[7:0]};
	endfunction

	// one decode, entered and left on a rising edge
	task automatic run_decode();
		bch_word_t cw;
		logic [14:0] mask;
		logic [3:0] p;
		int flips;
		cw.bits = encode(7'($urandom));
		flips = int'($urandom % 4);
		mask = '0;
		while ($countones(mask) < flips) begin // distinct positions only
			p = 4'($urandom % 15);
			mask[p] = 1'b1;
		end
		start <= 1'b1;
		word_in.bits <= cw.bits ^ mask;
		clean <= cw;
		@(posedge clk);
		start <= 1'b0;
		if ($urandom % 2 == 0) begin
			repeat (1 + $urandom % 12) @(posedge clk);
			start <= 1'b1; // lands while busy and must not give a second result
			word_in.bits <= 15'($urandom);
			@(posedge clk);
			start <= 1'b0;
		end
		while (!out_valid)
			@(posedge clk);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and closing report
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		void'($urandom(58));
		rst_n = 1'b0;
		start = 1'b0;
		word_in = '0;
		clean = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk); // idle cycles let the checker see a quiet DUT
		for (int d = 0; d < num_decodes; d++) begin
			run_decode();
			repeat ($urandom % 3) @(posedge clk); // gap of 0 to 2 cycles
		end
		repeat (2) @(posedge clk);
		$display("errors: %0d value, %0d protocol; %0d of %0d decodes checked",
			i_bch_checker.value_errors, i_bch_checker.protocol_errors,
			i_bch_checker.checked, num_decodes);
		if (i_bch_checker.value_errors == 0 && i_bch_checker.protocol_errors == 0 &&
				i_bch_checker.checked == num_decodes)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

endmodule

//--- dv/bch_checker.sv
`timescale 1ns/1ps

module bch_checker import bch_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,
	input bch_word_t word_in,
	input bch_word_t clean, // codeword before the flips, driven along with word_in
	input logic busy,
	input logic out_valid,
	input bch_word_t word_out,
	input bch_err_class_t err_class
);

	localparam int latency = 17; // accepted start to out_valid, in cycles

	int value_errors = 0;
	int protocol_errors = 0;
	int checked = 0; // decodes compared so far
	int cycles = 0; // sample edges since the accepted start
	logic pending; // a decode was in flight at this edge
	bch_word_t sent_q[$]; // received words of the decodes in flight
	bch_word_t clean_q[$];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference decoder
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// alpha^k by repeated multiplication with x, reduced by x^4 + x + 1
	function automatic logic [3:0] alpha_pow(input int k);
		logic [3:0] a;
		a = 4'h1;
		for (int i = 0; i < k % 15; i++)
			a = {a[2:0], 1'b0} ^ (a[3] ? 4'h3 : 4'h0);
		return a;
	endfunction

	// S1 in the upper nibble and S3 in the lower one
	function automatic logic [7:0] syndrome_of(input logic [14:0] w);
		logic [7:0] s;
		s = '0;
		for (int i = 0; i < 15; i++)
			if (w[i])
				s ^= {alpha_pow(i), alpha_pow(3 * i)};
		return s;
	endfunction

	// with S1 = alpha^k a lone error at k would give S3 = alpha^(3k)
	function automatic bch_err_class_t ref_class(input logic [14:0] w);
		logic [7:0] s;
		logic [3:0] lone_s3;
		s = syndrome_of(w);
		lone_s3 = '0;
		for (int k = 0; k < 15; k++)
			if (alpha_pow(k) == s[7:4])
				lone_s3 = alpha_pow(3 * k);
		if (s[7:4] == '0)
			return (s[3:0] == '0) ? err_none : err_uncorr;
		return (s[3:0] == lone_s3) ? err_one : err_two;
	endfunction

	task automatic report_protocol(input string msg);
		$display("protocol error at %0t: %s", $time, msg);
		protocol_errors++;
	endtask

	task automatic compare_result(input bch_word_t rx, input bch_word_t cw);
		bch_err_class_t exp_class;
		bch_word_t exp_word;
		logic check_word;
		int flips;
		string name;
		flips = $countones(rx.bits ^ cw.bits);
		name = $sformatf("decode_%0d_flips_%0d", checked, flips);
		check_word = 1'b1;
		exp_word = cw; // up to two errors are always undone
		exp_class = (flips < 3) ? bch_err_class_t'(2'(flips)) : ref_class(rx.bits);
		if (flips == 3) begin
			if (exp_class == err_uncorr)
				exp_word = rx; // handed back untouched
			else
				check_word = 1'b0; // three errors may land near another codeword
		end
		if (err_class != exp_class) begin
			$display("FAILED %s err_class expected %s actual %s", name,
				exp_class.name(), err_class.name());
			value_errors++;
		end
		if (check_word && word_out != exp_word) begin
			$display("FAILED %s word_out expected %h actual %h", name, exp_word, word_out);
			value_errors++;
		end
		checked++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// monitor
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk) begin
		if (!rst_n) begin
			sent_q.delete();
			clean_q.delete();
			cycles = 0;
		end else begin
			pending = (sent_q.size() != 0);
			if (pending != busy)
				report_protocol($sformatf("busy is %0b with %0d decodes in flight",
					busy, sent_q.size()));
			if (out_valid) begin
				if (!pending) begin
					report_protocol("out_valid arrived with no decode in flight");
				end else begin
					if (cycles != latency)
						report_protocol($sformatf("out_valid came %0d cycles after start",
							cycles));
					compare_result(sent_q.pop_front(), clean_q.pop_front());
				end
			end else if (pending && cycles >= latency) begin
				report_protocol("no out_valid 17 cycles after start");
				sent_q.delete(0);
				clean_q.delete(0);
			end
			cycles++;
			if (!pending && start) begin // a start while busy is dropped by the DUT
				sent_q.push_back(word_in);
				clean_q.push_back(clean);
				cycles = 1;
			end
		end
	end

endmodule

//--- dv/bch_assert.sv
`timescale 1ns/1ps

module bch_assert (
	input logic clk,
	input logic rst_n,
	input logic busy,
	input logic valid, // chien search in progress
	input logic first, // first search cycle
	input logic out_valid
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// strobe and busy protocol
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	out_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid) else $error("out_valid held for more than one cycle");

	// the result only leaves once the last position has been tested
	search_before_output: assert property (@(posedge clk) disable iff (!rst_n)
		!(valid && out_valid)) else $error("valid overlaps out_valid");

	first_in_search: assert property (@(posedge clk) disable iff (!rst_n)
		first |-> valid) else $error("first raised outside the search");

	// a reset cycle always leaves the decoder idle
	idle_after_reset: assert property (@(posedge clk)
		!rst_n |=> !busy) else $error("busy high right after reset");

endmodule

//--- src/bch_decoder_top.sv
`timescale 1ns/1ps

module bch_decoder_top import bch_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,
	input bch_word_t word_in,
	output logic busy,
	output bch_word_t word_out,
	output bch_err_class_t err_class,
	output logic out_valid
);

	bch_synd_t synd;
	logic synd_load;
	bch_synd_t cand;
	bch_pos_t pos;
	logic first;
	logic last;
	logic valid;
	logic err; // fed back into the chien running syndromes

	bch_syndrome i_bch_syndrome (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.busy(busy),
		.word_in(word_in),
		.synd(synd),
		.synd_load(synd_load)
	);

	bch_chien i_bch_chien (
		.clk(clk),
		.rst_n(rst_n),
		.synd_load(synd_load),
		.synd(synd),
		.err(err),
		.cand(cand),
		.pos(pos),
		.first(first),
		.last(last),
		.valid(valid)
	);

	bch_error_dec i_bch_error_dec (
		.clk(clk),
		.rst_n(rst_n),
		.cand(cand),
		.first(first),
		.valid(valid),
		.err(err),
		.err_class(err_class)
	);

	bch_correct i_bch_correct (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.busy(busy),
		.word_in(word_in),
		.err(err),
		.pos(pos),
		.last(last),
		.err_class(err_class),
		.word_out(word_out),
		.out_valid(out_valid)
	);

endmodule

//--- src/bch_correct.sv
`timescale 1ns/1ps

module bch_correct import bch_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,
	output logic busy, // a decode is in flight
	input bch_word_t word_in,
	input logic err, // the bit at pos is in error
	input bch_pos_t pos,
	input logic last, // final search cycle
	input bch_err_class_t err_class,
	output bch_word_t word_out, // held until the next out_valid
	output logic out_valid // one cycle pulse
);

	logic accept;
	bch_word_t word_rx; // received word, kept for the whole decode
	logic [bch_n-1:0] flip_mask; // error flags collected so far
	logic [bch_n-1:0] flip_now; // error flag of the current position

	assign accept = start && !busy;

	always_comb begin
		flip_now = '0;
		if (err)
			flip_now[pos] = 1'b1;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= last; // one cycle after the last position
			if (accept)
				busy <= 1'b1;
			else if (out_valid)
				busy <= 1'b0; // busy covers the out_valid cycle too
		end
	end

	// the flag of position 14 arrives with last, so it is merged in directly
	always_ff @(posedge clk) begin
		if (accept) begin
			word_rx <= word_in;
			flip_mask <= '0;
		end else begin
			flip_mask <= flip_mask ^ flip_now;
		end
		if (last) begin
			if (err_class == err_uncorr)
				word_out <= word_rx; // an uncorrectable word goes back untouched
			else
				word_out.bits <= word_rx.bits ^ flip_mask ^ flip_now;
		end
	end

endmodule

//--- src/error_dec/bch_error_dec.sv
`timescale 1ns/1ps

module bch_error_dec import gf_pkg::*, bch_pkg::*; (
	input logic clk,
	input logic rst_n,
	input bch_synd_t cand, // candidate syndromes from the chien search
	input logic first, // first search cycle
	input logic valid, // search in progress
	output logic err, // flipping the current position removes an error
	output bch_err_class_t err_class // class of the received word
);

	bch_err_class_t cand_class; // class of the candidate syndromes
	bch_err_class_t errors_last; // class of the running syndromes
	gf_elem_t s1_cubed;

	assign s1_cubed = gf_cube(cand.s1);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// classification
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// for t = 2 the error locator only depends on S1 and S3
	// one error leaves S3 = S1^3, two errors break that relation
	// S1 = 0 with S3 != 0 cannot come from two or fewer errors
	always_comb begin
		if (cand.s1 != '0) begin
			if (cand.s3 == s1_cubed)
				cand_class = err_one;
			else
				cand_class = err_two;
		end else if (cand.s3 != '0) begin
			cand_class = err_uncorr;
		end else begin
			cand_class = err_none;
		end
	end

	// a flip that lowers the error count hit an error position
	// nothing is ever corrected once the word is known to be uncorrectable,
	// errors_last cannot leave err_uncorr in that case so it carries the decision
	assign err = valid && (errors_last != err_uncorr) && (cand_class < errors_last);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// error count tracking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			errors_last <= err_none;
			err_class <= err_none;
		end else begin
			// outside the search cand carries the raw syndromes, so the edge that
			// ends the synd_load cycle leaves the starting class in errors_last
			if (!valid || err)
				errors_last <= cand_class;

			// starting class is reported for the whole word
			if (first)
				err_class <= errors_last;
		end
	end

endmodule

//--- src/error_dec/bch_chien.sv
`timescale 1ns/1ps

module bch_chien import gf_pkg::*, bch_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic synd_load, // new syndromes are present on synd
	input bch_synd_t synd,
	input logic err, // the flip tested this cycle removed an error
	output bch_synd_t cand, // syndromes seen if the current position were flipped
	output bch_pos_t pos, // position under test
	output logic first, // first search cycle, position 0
	output logic last, // final search cycle, position 14
	output logic valid // a position is under test
);

	chien_state_t state;
	bch_synd_t run; // syndromes with every error found so far removed
	bch_synd_t step; // alpha^pos in s1 and alpha^(3*pos) in s3

	assign valid = (state == ch_run);
	assign last = valid && (pos == bch_pos_last);

	// while idle the raw syndromes are passed through so that the error
	// decoder can take the starting class during the synd_load cycle
	assign cand = valid ? bch_synd_t'(run ^ step) : synd;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ch_idle;
			pos <= '0;
			first <= 1'b0;
		end else begin
			first <= synd_load; // search always starts right after the load
			case (state)
				ch_idle: begin
					if (synd_load) begin
						state <= ch_run;
						pos <= '0;
					end
				end
				ch_run: begin
					pos <= pos + bch_pos_t'(1); // one position per cycle
					if (last)
						state <= ch_idle; // 15 positions done
				end
				default: state <= ch_idle;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// running syndromes and step terms
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// flipping bit i moves S1 by alpha^i and S3 by alpha^(3i), so the step
	// terms walk through those powers as pos counts up
	always_ff @(posedge clk) begin
		if (synd_load) begin
			run <= synd;
			step.s1 <= gf_one; // alpha^0 for position 0
			step.s3 <= gf_one;
		end else if (valid) begin
			if (err)
				run <= bch_synd_t'(run ^ step); // keep the flip, the error is gone
			step.s1 <= gf_mul(step.s1, gf_alpha);
			step.s3 <= gf_mul(step.s3, gf_alpha3);
		end
	end

endmodule

//--- src/syndrome/bch_syndrome.sv
`timescale 1ns/1ps

module bch_syndrome import gf_pkg::*, bch_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start, // sampled together with word_in
	input logic busy, // a start while busy is dropped
	input bch_word_t word_in,
	output bch_synd_t synd, // held until the next accepted start
	output logic synd_load // one cycle pulse, synd is valid with it
);

	logic accept; // start that actually begins a decode
	bch_synd_t synd_next;

	assign accept = start && !busy;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// syndrome evaluation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// each set bit i adds alpha^i to S1 and alpha^(3i) to S3
	// the whole word is folded in one cycle since the code is only 15 bits wide
	always_comb begin
		synd_next = '0;
		for (int i = 0; i < bch_n; i++) begin
			if (word_in.bits[i]) begin
				synd_next.s1 ^= gf_pow_tab[i];
				synd_next.s3 ^= gf_pow_tab[(3 * i) % gf_order]; // exponent wraps at 15
			end
		end
	end

	// syndromes only change on a new word
	always_ff @(posedge clk) begin
		if (accept)
			synd <= synd_next;
	end

	// the load pulse follows the accepted start by exactly one cycle
	always_ff @(posedge clk) begin
		if (!rst_n)
			synd_load <= 1'b0;
		else
			synd_load <= accept;
	end

endmodule

//--- common/bch_pkg.sv
package bch_pkg;

	import gf_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// BCH(15,7) code shape, t = 2
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int bch_n = 15; // code length, one bit per nonzero field element

	typedef logic [3:0] bch_pos_t; // bit position 0 to 14

	localparam bch_pos_t bch_pos_last = 4'd14; // last position visited by the search

	// received or corrected codeword, bit i is paired with alpha^i
	typedef struct packed {
		logic [bch_n-1:0] bits;
	} bch_word_t;

	// the two independent syndromes of a double error correcting code
	typedef struct packed {
		gf_elem_t s1; // sum of alpha^i over the set bits
		gf_elem_t s3; // sum of alpha^(3i) over the set bits
	} bch_synd_t;

	// ordered so that a smaller value means fewer errors
	typedef enum logic [1:0] {
		err_none = 2'd0, // both syndromes zero
		err_one = 2'd1, // S1 nonzero and S3 equal to S1 cubed
		err_two = 2'd2, // S1 nonzero otherwise
		err_uncorr = 2'd3 // S1 zero but S3 nonzero
	} bch_err_class_t;

	// chien search sequencer
	typedef enum logic {
		ch_idle = 1'b0,
		ch_run = 1'b1
	} chien_state_t;

endpackage

//--- common/gf_pkg.sv
package gf_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// GF(2^4) built on x^4 + x + 1
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int gf_m = 4; // bits per field element
	localparam int gf_order = 15; // multiplicative order of alpha

	typedef logic [gf_m-1:0] gf_elem_t; // polynomial basis, bit k is the x^k coefficient

	localparam gf_elem_t gf_poly = 4'h3; // x + 1, folded back in when x^4 falls out
	localparam gf_elem_t gf_one = 4'h1;
	localparam gf_elem_t gf_alpha = 4'h2; // chien step for S1
	localparam gf_elem_t gf_alpha3 = 4'h8; // chien step for S3

	// alpha^k for k = 0 up to 14, alpha^0 sits in the lowest nibble
	localparam logic [gf_order-1:0][gf_m-1:0] gf_pow_tab = {
		4'h9, 4'hd, 4'hf, 4'he, 4'h7,
		4'ha, 4'h5, 4'hb, 4'hc, 4'h6,
		4'h3, 4'h8, 4'h4, 4'h2, 4'h1
	};

	// shift and add multiply, a is doubled once per bit of b
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i])
				acc ^= sh; // add this partial product
			sh = {sh[gf_m-2:0], 1'b0} ^ (sh[gf_m-1] ? gf_poly : '0); // sh times x, reduced
		end
		return acc;
	endfunction

	// a^3 is what S3 must equal when exactly one error is present
	function automatic gf_elem_t gf_cube(input gf_elem_t a);
		return gf_mul(gf_mul(a, a), a);
	endfunction

endpackage
